// File: src/lc3b_pkg.sv
package lc3b_pkg;

	// data path and tag sizes.
	localparam int word_width   = 16; // one LC-3b word.
	localparam int tag_width    = 3;  // enough for all stations in the core.
	localparam int opcode_width = 4;  // instr[15:12].
	localparam int aluop_width  = 3;  // seven ALU functions.

	// stations in this cluster.
	localparam int num_stations = 2; // two ALU stations side by side.

	// LC-3b opcodes handled by the integer cluster.
	localparam logic [opcode_width-1:0] op_add = 4'b0001; // register or imm5 add.
	localparam logic [opcode_width-1:0] op_and = 4'b0101; // register or imm5 and.
	localparam logic [opcode_width-1:0] op_not = 4'b1001; // bitwise invert of sr1.
	localparam logic [opcode_width-1:0] op_shf = 4'b1101; // shift by imm4.

	// ALU function select.
	localparam logic [aluop_width-1:0] alu_add  = 3'd0; // a + b.
	localparam logic [aluop_width-1:0] alu_and  = 3'd1; // a & b.
	localparam logic [aluop_width-1:0] alu_not  = 3'd2; // ~a.
	localparam logic [aluop_width-1:0] alu_pass = 3'd3; // a unchanged.
	localparam logic [aluop_width-1:0] alu_sll  = 3'd4; // shift left logical.
	localparam logic [aluop_width-1:0] alu_srl  = 3'd5; // shift right logical.
	localparam logic [aluop_width-1:0] alu_sra  = 3'd6; // shift right arithmetic.

	// a zero tag never names a producer.
	localparam logic [tag_width-1:0] tag_none = 3'd0; // operand already holds its value.

endpackage : lc3b_pkg

// File: src/alu_op_decode.sv
module alu_op_decode
	import lc3b_pkg::*;
(
	input  logic [opcode_width-1:0] op,    // stored opcode.
	input  logic                    shf_a, // instr[5], arithmetic right shift.
	input  logic                    shf_d, // instr[4], shift direction.
	output logic [aluop_width-1:0]  aluop  // function select to the ALU.
);

	always_comb
	begin
		aluop = alu_pass; // anything not listed just passes a.
		case (op)
			op_add:
			begin
				aluop = alu_add; // imm5 already sits in vk.
			end
			op_and:
			begin
				aluop = alu_and;
			end
			op_not:
			begin
				aluop = alu_not; // only sr1 matters.
			end
			op_shf:
			begin
				// d = 0 is lshf, otherwise a picks rshfa over rshfl.
				if (!shf_d)
					aluop = alu_sll; // lshf.
				else if (shf_a)
					aluop = alu_sra; // rshfa keeps the sign.
				else
					aluop = alu_srl; // rshfl fills zeros.
			end
			default:
			begin
				aluop = alu_pass; // not an ALU opcode.
			end
		endcase
	end

endmodule : alu_op_decode

// File: src/lc3b_alu.sv
module lc3b_alu
	import lc3b_pkg::*;
(
	input  logic [aluop_width-1:0] aluop, // function select.
	input  logic [word_width-1:0]  a,     // vj operand.
	input  logic [word_width-1:0]  b,     // vk operand or immediate.
	output logic [word_width-1:0]  f      // result.
);

	logic [3:0] shamt; // imm4 shift count.

	assign shamt = b[3:0]; // upper bits of b ignored for shifts.

	always_comb
	begin
		case (aluop)
			alu_add:
				f = a + b; // wraps at 16 bits.
			alu_and:
				f = a & b;
			alu_not:
				f = ~a;
			alu_pass:
				f = a;
			alu_sll:
				f = a << shamt;
			alu_srl:
				f = a >> shamt; // zero fill.
			alu_sra:
				f = $unsigned($signed(a) >>> shamt); // sign fill.
			default:
				f = a; // unused code behaves as pass.
		endcase
	end

endmodule : lc3b_alu

// File: src/alu_res_station.sv
module alu_res_station
	import lc3b_pkg::*;
#(
	parameter logic [tag_width-1:0] my_tag = 3'd1 // tag this station broadcasts.
)
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    flush,         // drop whatever is held.
	input  logic                    ld,            // issue strobe for this station.
	input  logic [opcode_width-1:0] op,
	input  logic [word_width-1:0]   instr,
	input  logic [word_width-1:0]   vj,
	input  logic [word_width-1:0]   vk,
	input  logic                    vj_valid,
	input  logic                    vk_valid,
	input  logic [tag_width-1:0]    qj,            // producer of vj when not valid.
	input  logic [tag_width-1:0]    qk,            // producer of vk when not valid.
	input  logic [tag_width-1:0]    dest,          // issue unit's name for this entry.
	input  logic                    cdb_valid,     // cluster CDB.
	input  logic [tag_width-1:0]    cdb_tag,
	input  logic [word_width-1:0]   cdb_data,
	input  logic                    ext_cdb_valid, // CDB from other units.
	input  logic [tag_width-1:0]    ext_cdb_tag,
	input  logic [word_width-1:0]   ext_cdb_data,
	input  logic                    grant,         // result taken by the arbiter.
	output logic                    busy,
	output logic                    rdy,
	output logic [tag_width-1:0]    res_tag,
	output logic [word_width-1:0]   res_data
);

	logic [opcode_width-1:0] op_q;       // stored opcode.
	logic                    shf_a_q;    // instr[5].
	logic                    shf_d_q;    // instr[4].
	logic [word_width-1:0]   vj_q;
	logic [word_width-1:0]   vk_q;
	logic                    vj_valid_q;
	logic                    vk_valid_q;
	logic [tag_width-1:0]    qj_q;
	logic [tag_width-1:0]    qk_q;
	logic                    j_cdb_hit;  // vj producer on cluster CDB.
	logic                    j_ext_hit;  // vj producer on external CDB.
	logic                    k_cdb_hit;
	logic                    k_ext_hit;
	logic [aluop_width-1:0]  aluop;

	// tag match against both buses, only for operands still waiting.
	assign j_cdb_hit = busy && !vj_valid_q && cdb_valid && (cdb_tag == qj_q);
	assign j_ext_hit = busy && !vj_valid_q && ext_cdb_valid && (ext_cdb_tag == qj_q);
	assign k_cdb_hit = busy && !vk_valid_q && cdb_valid && (cdb_tag == qk_q);
	assign k_ext_hit = busy && !vk_valid_q && ext_cdb_valid && (ext_cdb_tag == qk_q);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			busy <= 1'b0;
		else if (flush || grant)
			busy <= 1'b0; // freed at the edge the result goes out.
		else if (ld)
			busy <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (ld)
		begin
			op_q       <= op;
			shf_a_q    <= instr[5];
			shf_d_q    <= instr[4];
			vj_q       <= vj;
			vk_q       <= vk; // immediates arrive here already valid.
			vj_valid_q <= vj_valid;
			vk_valid_q <= vk_valid;
			qj_q       <= vj_valid ? tag_none : qj;
			qk_q       <= vk_valid ? tag_none : qk;
		end
		else
		begin
			// cluster CDB wins when both buses carry the tag.
			if (j_cdb_hit)
			begin
				vj_q       <= cdb_data;
				vj_valid_q <= 1'b1;
				qj_q       <= tag_none;
			end
			else if (j_ext_hit)
			begin
				vj_q       <= ext_cdb_data;
				vj_valid_q <= 1'b1;
				qj_q       <= tag_none;
			end
			if (k_cdb_hit)
			begin
				vk_q       <= cdb_data;
				vk_valid_q <= 1'b1;
				qk_q       <= tag_none;
			end
			else if (k_ext_hit)
			begin
				vk_q       <= ext_cdb_data;
				vk_valid_q <= 1'b1;
				qk_q       <= tag_none;
			end
		end
	end

	alu_op_decode alu_op_decode_i (
		.op    (op_q),
		.shf_a (shf_a_q),
		.shf_d (shf_d_q),
		.aluop (aluop)
	);

	lc3b_alu lc3b_alu_i (
		.aluop (aluop),
		.a     (vj_q),
		.b     (vk_q),
		.f     (res_data) // result is live as soon as operands settle.
	);

	assign rdy     = busy && vj_valid_q && vk_valid_q; // grant drops busy, so rdy too.
	assign res_tag = my_tag;

	// issue unit only loads a free station.
	ld_only_when_free: assert property (@(posedge clk) disable iff (!rst_n)
		ld |-> !busy)
		else $error("station %0d loaded while busy.", my_tag);

	// destination tag handed out must name this station.
	ld_dest_matches: assert property (@(posedge clk) disable iff (!rst_n)
		ld |-> (dest == my_tag))
		else $error("station %0d loaded with dest %0d.", my_tag, dest);

	// arbiter only takes a finished result.
	grant_needs_rdy: assert property (@(posedge clk) disable iff (!rst_n)
		grant |-> rdy)
		else $error("station %0d granted while not ready.", my_tag);

endmodule : alu_res_station

// File: src/cdb_arbiter.sv
module cdb_arbiter
	import lc3b_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  flush,     // no grant, no broadcast.
	input  logic                  rdy0,
	input  logic [tag_width-1:0]  res_tag0,
	input  logic [word_width-1:0] res_data0,
	input  logic                  rdy1,
	input  logic [tag_width-1:0]  res_tag1,
	input  logic [word_width-1:0] res_data1,
	output logic                  grant0,    // one-cycle take from station 0.
	output logic                  grant1,    // one-cycle take from station 1.
	output logic                  cdb_valid, // registered cluster CDB.
	output logic [tag_width-1:0]  cdb_tag,
	output logic [word_width-1:0] cdb_data
);

	logic ptr;     // 0 favors station 0, 1 favors station 1.
	logic any_gnt; // some station wins this cycle.

	// favored station wins a tie; a lone ready station always wins.
	assign grant0  = !flush && rdy0 && (!rdy1 || !ptr);
	assign grant1  = !flush && rdy1 && (!rdy0 || ptr);
	assign any_gnt = grant0 || grant1;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ptr       <= 1'b0;
			cdb_valid <= 1'b0;
		end
		else
		begin
			cdb_valid <= any_gnt; // flush already blocked the grant.
			if (any_gnt)
				ptr <= !ptr; // priority flips on every grant.
		end
	end

	// payload only meaningful with cdb_valid.
	always_ff @(posedge clk)
	begin
		if (grant0)
		begin
			cdb_tag  <= res_tag0;
			cdb_data <= res_data0;
		end
		else if (grant1)
		begin
			cdb_tag  <= res_tag1;
			cdb_data <= res_data1;
		end
	end

	// the bus carries one result per cycle.
	one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({grant1, grant0}))
		else $error("both stations granted in one cycle.");

endmodule : cdb_arbiter

// File: src/alu_cluster.sv
module alu_cluster
	import lc3b_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    flush,
	input  logic                    ld0,            // load station with tag 1.
	input  logic                    ld1,            // load station with tag 2.
	input  logic [opcode_width-1:0] issue_op,
	input  logic [word_width-1:0]   issue_instr,
	input  logic [word_width-1:0]   issue_vj,
	input  logic [word_width-1:0]   issue_vk,
	input  logic                    issue_vj_valid,
	input  logic                    issue_vk_valid,
	input  logic [tag_width-1:0]    issue_qj,
	input  logic [tag_width-1:0]    issue_qk,
	input  logic [tag_width-1:0]    issue_dest,
	input  logic                    ext_cdb_valid,
	input  logic [tag_width-1:0]    ext_cdb_tag,
	input  logic [word_width-1:0]   ext_cdb_data,
	output logic                    busy0,
	output logic                    busy1,
	output logic                    cdb_valid,
	output logic [tag_width-1:0]    cdb_tag,
	output logic [word_width-1:0]   cdb_data
);

	logic [num_stations-1:0] rdy;                     // per-station result ready.
	logic [num_stations-1:0] grant;                   // per-station take.
	logic [tag_width-1:0]    res_tag  [num_stations]; // per-station tag.
	logic [word_width-1:0]   res_data [num_stations]; // per-station result.

	alu_res_station #(.my_tag(3'd1)) alu_res_station_0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush         (flush),
		.ld            (ld0),
		.op            (issue_op),
		.instr         (issue_instr),
		.vj            (issue_vj),
		.vk            (issue_vk),
		.vj_valid      (issue_vj_valid),
		.vk_valid      (issue_vk_valid),
		.qj            (issue_qj),
		.qk            (issue_qk),
		.dest          (issue_dest),
		.cdb_valid     (cdb_valid),     // own bus fed back for wakeup.
		.cdb_tag       (cdb_tag),
		.cdb_data      (cdb_data),
		.ext_cdb_valid (ext_cdb_valid),
		.ext_cdb_tag   (ext_cdb_tag),
		.ext_cdb_data  (ext_cdb_data),
		.grant         (grant[0]),
		.busy          (busy0),
		.rdy           (rdy[0]),
		.res_tag       (res_tag[0]),
		.res_data      (res_data[0])
	);

	alu_res_station #(.my_tag(3'd2)) alu_res_station_1 (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush         (flush),
		.ld            (ld1),
		.op            (issue_op),
		.instr         (issue_instr),
		.vj            (issue_vj),
		.vk            (issue_vk),
		.vj_valid      (issue_vj_valid),
		.vk_valid      (issue_vk_valid),
		.qj            (issue_qj),
		.qk            (issue_qk),
		.dest          (issue_dest),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_data      (cdb_data),
		.ext_cdb_valid (ext_cdb_valid),
		.ext_cdb_tag   (ext_cdb_tag),
		.ext_cdb_data  (ext_cdb_data),
		.grant         (grant[1]),
		.busy          (busy1),
		.rdy           (rdy[1]),
		.res_tag       (res_tag[1]),
		.res_data      (res_data[1])
	);

	cdb_arbiter cdb_arbiter_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.rdy0      (rdy[0]),
		.res_tag0  (res_tag[0]),
		.res_data0 (res_data[0]),
		.rdy1      (rdy[1]),
		.res_tag1  (res_tag[1]),
		.res_data1 (res_data[1]),
		.grant0    (grant[0]),
		.grant1    (grant[1]),
		.cdb_valid (cdb_valid), // sole driver of the cluster CDB.
		.cdb_tag   (cdb_tag),
		.cdb_data  (cdb_data)
	);

endmodule : alu_cluster

// File: tb/tb_alu_cluster.sv
module tb_alu_cluster
	import lc3b_pkg::*;
();

	logic                    clk = 1'b0;
	logic                    rst_n, flush, ld0, ld1;
	logic [opcode_width-1:0] issue_op;
	logic [word_width-1:0]   issue_instr, issue_vj, issue_vk;
	logic                    issue_vj_valid, issue_vk_valid;
	logic [tag_width-1:0]    issue_qj, issue_qk, issue_dest;
	logic                    ext_cdb_valid;
	logic [tag_width-1:0]    ext_cdb_tag;
	logic [word_width-1:0]   ext_cdb_data;
	logic                    busy0, busy1, cdb_valid;
	logic [tag_width-1:0]    cdb_tag;
	logic [word_width-1:0]   cdb_data;

	int    seed      = 13639;   // fixed stimulus seed.
	int    errors    = 0;
	int    timeouts  = 0;
	string test_name = "reset";

	// reference model, one entry per tag.
	logic [opcode_width-1:0] m_op     [8];
	logic [word_width-1:0]   m_instr  [8];
	logic [word_width-1:0]   m_vj     [8];
	logic [word_width-1:0]   m_vk     [8];
	logic [tag_width-1:0]    m_qj     [8]; // tag_none once the value is known.
	logic [tag_width-1:0]    m_qk     [8];
	logic [word_width-1:0]   exp_data [8];
	logic                    pending  [8]; // issued, result not yet seen.
	logic                    seen_load = 1'b0;
	logic                    fast_ld   = 1'b0; // uncontended load with both operands.
	logic [tag_width-1:0]    fast_tag  = tag_none;
	logic                    both_wake = 1'b0; // both stations woken together.
	logic [tag_width-1:0]    exp_first = tag_none;
	logic                    rr_ptr    = 1'b0; // mirrors the arbiter priority.

	always #20 clk = ~clk;

	alu_cluster alu_cluster_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush          (flush),
		.ld0            (ld0),
		.ld1            (ld1),
		.issue_op       (issue_op),
		.issue_instr    (issue_instr),
		.issue_vj       (issue_vj),
		.issue_vk       (issue_vk),
		.issue_vj_valid (issue_vj_valid),
		.issue_vk_valid (issue_vk_valid),
		.issue_qj       (issue_qj),
		.issue_qk       (issue_qk),
		.issue_dest     (issue_dest),
		.ext_cdb_valid  (ext_cdb_valid),
		.ext_cdb_tag    (ext_cdb_tag),
		.ext_cdb_data   (ext_cdb_data),
		.busy0          (busy0),
		.busy1          (busy1),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_data       (cdb_data)
	);

	// LC-3b semantics, sign fill built by hand.
	function automatic logic [word_width-1:0] expected_result(input logic [opcode_width-1:0] op,
		input logic [word_width-1:0] instr, input logic [word_width-1:0] a,
		input logic [word_width-1:0] b);
		logic [word_width-1:0] r;
		r = a; // unknown opcodes pass a.
		case (op)
			op_add: r = a + b;
			op_and: r = a & b;
			op_not: r = ~a;
			op_shf:
			begin
				if (!instr[4])
					r = a << b[3:0];
				else
				begin
					r = a >> b[3:0];
					if (instr[5] && a[15])
						r = r | ~(16'hffff >> b[3:0]); // copies of the sign bit.
				end
			end
			default: r = a;
		endcase
		return r;
	endfunction

	function automatic logic [word_width-1:0] rand_word();
		return 16'($random(seed));
	endfunction

	// kinds 0..5 are add, and, not, lshf, rshfl, rshfa.
	function automatic logic [word_width-1:0] make_instr(input int kind);
		logic [word_width-1:0] w;
		w = rand_word();
		w[15:12] = (kind == 0) ? op_add : (kind == 1) ? op_and : (kind == 2) ? op_not : op_shf;
		if (kind == 3)
			w[4] = 1'b0;
		if (kind == 4)
			w[5:4] = 2'b01;
		if (kind == 5)
			w[5:4] = 2'b11;
		return w;
	endfunction

	// broadcast value reaches every waiting operand.
	task automatic wake(input logic [tag_width-1:0] tag, input logic [word_width-1:0] data);
		logic [word_width-1:0] vj, vk;
		logic [tag_width-1:0]  qj, qk;
		for (int t = 1; t <= 2; t++)
		begin
			vj = (m_qj[t] == tag) ? data : m_vj[t];
			vk = (m_qk[t] == tag) ? data : m_vk[t];
			qj = (m_qj[t] == tag) ? tag_none : m_qj[t];
			qk = (m_qk[t] == tag) ? tag_none : m_qk[t];
			if (pending[t])
			begin
				m_vj[t] <= vj;
				m_vk[t] <= vk;
				m_qj[t] <= qj;
				m_qk[t] <= qk;
				if (qj == tag_none && qk == tag_none)
					exp_data[t] <= expected_result(m_op[t], m_instr[t], vj, vk);
			end
		end
	endtask

	// qj or qk other than tag_none marks that operand as waiting.
	task automatic issue(input int st, input logic [word_width-1:0] instr,
		input logic [word_width-1:0] vj, input logic [word_width-1:0] vk,
		input logic [tag_width-1:0] qj, input logic [tag_width-1:0] qk, input logic fast);
		logic [tag_width-1:0] tag;
		tag = tag_width'(st + 1); // station 0 is tag 1.
		@(posedge clk);
		ld0            <= (st == 0);
		ld1            <= (st == 1);
		issue_op       <= instr[15:12];
		issue_instr    <= instr;
		issue_vj       <= vj;
		issue_vk       <= vk;
		issue_vj_valid <= (qj == tag_none);
		issue_vk_valid <= (qk == tag_none);
		issue_qj       <= qj;
		issue_qk       <= qk;
		issue_dest     <= tag;
		fast_ld        <= fast;
		seen_load      <= 1'b1;
		if (fast)
			fast_tag <= tag;
		m_op[tag]     <= instr[15:12];
		m_instr[tag]  <= instr;
		m_vj[tag]     <= vj;
		m_vk[tag]     <= vk;
		m_qj[tag]     <= qj;
		m_qk[tag]     <= qk;
		pending[tag]  <= 1'b1;
		exp_data[tag] <= expected_result(instr[15:12], instr, vj, vk); // redone on wakeup.
	endtask

	task automatic end_strobes();
		@(posedge clk);
		ld0           <= 1'b0;
		ld1           <= 1'b0;
		flush         <= 1'b0;
		fast_ld       <= 1'b0;
		ext_cdb_valid <= 1'b0;
		both_wake     <= 1'b0;
	endtask

	task automatic broadcast(input logic [tag_width-1:0] tag, input logic contend);
		logic [word_width-1:0] data;
		data = rand_word();
		@(posedge clk);
		ext_cdb_valid <= 1'b1;
		ext_cdb_tag   <= tag;
		ext_cdb_data  <= data;
		both_wake     <= contend;
		exp_first     <= rr_ptr ? 3'd2 : 3'd1; // favored station goes first.
		wake(tag, data);
	endtask

	task automatic flush_all();
		@(posedge clk);
		flush <= 1'b1;
		ld0   <= 1'b0;
		ld1   <= 1'b0;
		for (int t = 1; t <= 2; t++)
			pending[t] <= 1'b0; // flushed work never reaches the bus.
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(posedge clk);
		while ((busy0 || busy1 || cdb_valid) && n < 40)
		begin
			@(posedge clk);
			n++;
		end
		if (busy0 || busy1 || cdb_valid)
		begin
			timeouts++;
			$display("timeout in %s: the cluster never went idle", test_name);
		end
	endtask

	// own CDB results retire and wake waiters.
	always @(posedge clk)
	begin
		if (rst_n && cdb_valid)
		begin
			pending[cdb_tag] <= 1'b0;
			rr_ptr           <= !rr_ptr;
			wake(cdb_tag, exp_data[cdb_tag]);
		end
	end

	reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!seen_load |-> (!busy0 && !busy1 && !cdb_valid))
		else
		begin
			errors++;
			$display("error in %s: busy or cdb_valid high before the first load", test_name);
		end

	result_value: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> (cdb_data == exp_data[cdb_tag]))
		else
		begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", test_name,
				$sampled(exp_data[cdb_tag]), $sampled(cdb_data));
		end

	result_once: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> pending[cdb_tag])
		else
		begin
			errors++;
			$display("error in %s: tag %0d on the CDB with no result owed", test_name,
				$sampled(cdb_tag));
		end

	result_after_wakeup: assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> (m_qj[cdb_tag] == tag_none && m_qk[cdb_tag] == tag_none))
		else
		begin
			errors++;
			$display("error in %s: tag %0d sent before its operands arrived", test_name,
				$sampled(cdb_tag));
		end

	result_latency: assert property (@(posedge clk) disable iff (!rst_n)
		fast_ld |=> !cdb_valid ##1 (cdb_valid && cdb_tag == fast_tag))
		else
		begin
			errors++;
			$display("[ERROR] %s: expected tag %0d, actual valid %b tag %0d", test_name,
				$sampled(fast_tag), $sampled(cdb_valid), $sampled(cdb_tag));
		end

	contention_order: assert property (@(posedge clk) disable iff (!rst_n)
		both_wake |=> !cdb_valid ##1 (cdb_valid && cdb_tag == exp_first)
		##1 (cdb_valid && cdb_tag == 3'd3 - exp_first))
		else
		begin
			errors++;
			$display("[ERROR] %s: expected first tag %0d, actual valid %b tag %0d", test_name,
				$sampled(exp_first), $sampled(cdb_valid), $sampled(cdb_tag));
		end

	flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> (!busy0 && !busy1 && !cdb_valid))
		else
		begin
			errors++;
			$display("error in %s: station busy or CDB active after flush", test_name);
		end

	initial
	begin
		logic [word_width-1:0] instr;
		for (int t = 0; t < 8; t++)
		begin
			pending[t] = 1'b0;
			m_qj[t]    = tag_none;
			m_qk[t]    = tag_none;
		end
		rst_n          <= 1'b0;
		flush          <= 1'b0;
		ld0            <= 1'b0;
		ld1            <= 1'b0;
		issue_op       <= '0;
		issue_instr    <= '0;
		issue_vj       <= '0;
		issue_vk       <= '0;
		issue_vj_valid <= 1'b0;
		issue_vk_valid <= 1'b0;
		issue_qj       <= tag_none;
		issue_qk       <= tag_none;
		issue_dest     <= tag_none;
		ext_cdb_valid  <= 1'b0;
		ext_cdb_tag    <= tag_none;
		ext_cdb_data   <= '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk); // idle outputs checked here.

		test_name = "result";
		for (int i = 0; i < 12; i++)
		begin
			issue(i % 2, make_instr(i % 6), rand_word(), rand_word(), tag_none, tag_none, 1'b1);
			end_strobes();
			wait_idle();
		end

		test_name = "ext_wakeup";
		issue(0, make_instr($unsigned($random(seed)) % 6), rand_word(), rand_word(), 3'd5,
			tag_none, 1'b0); // vj from tag 5.
		end_strobes();
		repeat (4) @(posedge clk);
		broadcast(3'd5, 1'b0);
		end_strobes();
		wait_idle();
		issue(1, make_instr($unsigned($random(seed)) % 6), rand_word(), rand_word(), tag_none,
			3'd4, 1'b0); // vk from tag 4.
		end_strobes();
		repeat (4) @(posedge clk);
		broadcast(3'd4, 1'b0);
		end_strobes();
		wait_idle();

		test_name = "forward";
		instr = make_instr($unsigned($random(seed)) % 6);
		issue(1, instr, rand_word(), rand_word(), 3'd1, tag_none, 1'b0); // vj from station 1.
		issue(0, make_instr($unsigned($random(seed)) % 6), rand_word(), rand_word(), tag_none,
			tag_none, 1'b0);
		end_strobes();
		wait_idle();

		test_name = "contention";
		for (int c = 0; c < 2; c++)
		begin
			issue(0, make_instr(c), rand_word(), rand_word(), 3'd5, tag_none, 1'b0);
			issue(1, make_instr(c + 3), rand_word(), rand_word(), tag_none, 3'd5, 1'b0);
			end_strobes();
			broadcast(3'd5, 1'b1);
			end_strobes();
			wait_idle();
			issue(0, make_instr(0), rand_word(), rand_word(), tag_none, tag_none, 1'b1);
			end_strobes(); // odd grant count flips the next winner.
			wait_idle();
		end

		test_name = "flush";
		issue(0, make_instr(1), rand_word(), rand_word(), tag_none, tag_none, 1'b0);
		flush_all(); // kills the grant in the ready cycle.
		end_strobes();
		wait_idle();
		issue(0, make_instr(2), rand_word(), rand_word(), 3'd6, tag_none, 1'b0);
		issue(1, make_instr(4), rand_word(), rand_word(), tag_none, 3'd6, 1'b0);
		end_strobes();
		flush_all();
		end_strobes();
		broadcast(3'd6, 1'b0); // nobody left to wake.
		end_strobes();
		repeat (4) @(posedge clk);
		wait_idle();

		$display("checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule : tb_alu_cluster

// File: sources.f
src/lc3b_pkg.sv
src/alu_op_decode.sv
src/lc3b_alu.sv
src/alu_res_station.sv
src/cdb_arbiter.sv
src/alu_cluster.sv
tb/tb_alu_cluster.sv

// File: Bender.yml
package:
  name: alu_cluster

sources:
  # shared package
  - files:
      - src/lc3b_pkg.sv
  # RTL
  - files:
      - src/alu_op_decode.sv
      - src/lc3b_alu.sv
      - src/alu_res_station.sv
      - src/cdb_arbiter.sv
      - src/alu_cluster.sv
  # testbench
  - target: test
    files:
      - tb/tb_alu_cluster.sv
